// ==== rtl/mem_io_pkg.sv ====
`default_nettype none

package mem_io_pkg;

   // ----------------------------------------------------------
   // Widths
   // ----------------------------------------------------------
   localparam int ADDR_SZ = 32;                              // Load/store address width
   localparam int RSZ     = 32;                              // Data word width

   // ----------------------------------------------------------
   // Address map
   // ----------------------------------------------------------
   // Internal register window, machine timer block
   localparam logic [ADDR_SZ-1:0] INT_IO_LO     = 32'h0200_0000;
   localparam logic [ADDR_SZ-1:0] INT_IO_HI     = 32'h0200_FFFF;
   localparam logic [ADDR_SZ-1:0] MSIP_ADDR     = 32'h0200_0000; // One word
   localparam logic [ADDR_SZ-1:0] MTIMECMP_ADDR = 32'h0200_4000; // Two words, low first
   localparam logic [ADDR_SZ-1:0] MTIME_ADDR    = 32'h0200_BFF8; // Two words, low first

   // External I/O window, everything else goes to the L1 D$
   localparam logic [ADDR_SZ-1:0] EXT_IO_LO     = 32'h1000_0000;
   localparam logic [ADDR_SZ-1:0] EXT_IO_HI     = 32'h1FFF_FFFF;

   // Access size in bytes
   typedef logic [2:0] size_t;
   localparam size_t SZ_BYTE = 3'd1;
   localparam size_t SZ_HALF = 3'd2;
   localparam size_t SZ_WORD = 3'd4;                         // Only size allowed on timer regs

   // ----------------------------------------------------------
   // Port payloads
   // ----------------------------------------------------------
   typedef struct packed {
      logic [ADDR_SZ-1:0] rw_addr;                           // Load/store address
      logic               rd;                                // Load
      logic               wr;                                // Store
      logic [RSZ-1:0]     wr_data;                           // Store data
      size_t              size;                              // 1, 2 or 4 bytes
      logic               zero_ext;                          // 1 = zero extend load
   } dc_req_t;

   typedef struct packed {
      logic [RSZ-1:0] data;                                  // Load data from D$
   } dc_rsp_t;

   typedef struct packed {
      logic [ADDR_SZ-1:0] addr;
      logic               rd;
      logic               wr;
      logic [RSZ-1:0]     wr_data;
   } io_req_t;

   typedef struct packed {
      logic [RSZ-1:0] data;
      logic           fault;                                 // Device reported an access fault
   } io_rsp_t;

   // Timer register select
   typedef enum logic [2:0] {
      MMR_MSIP,
      MMR_MTIME_LO,
      MMR_MTIME_HI,
      MMR_MTIMECMP_LO,
      MMR_MTIMECMP_HI
   } mmr_sel_t;

endpackage

`default_nettype wire

// ==== rtl/port_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Decoder to outward bus port link, payload types set per instance
interface port_if #(
   parameter type req_t = logic,
   parameter type rsp_t = logic
);

   logic start;                                              // One cycle, decoder to port
   req_t req;                                                // Valid with start
   logic done;                                               // One cycle, port to decoder
   rsp_t rsp;                                                // Valid with done

   // Decoder side
   modport ctrl (
      output start,
      output req,
      input  done,
      input  rsp
   );

   // Bus port side
   modport port (
      input  start,
      input  req,
      output done,
      output rsp
   );

endinterface

`default_nettype wire

// ==== rtl/mmr_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Decoder to timer register block
interface mmr_if;
   import mem_io_pkg::*;

   logic           wr;                                       // Write strobe, acts at the clock edge
   mmr_sel_t       sel;                                      // Register being accessed
   logic [RSZ-1:0] wr_data;
   logic [RSZ-1:0] rd_data;                                  // Combinational, follows sel

   modport ctrl (
      output wr,
      output sel,
      output wr_data,
      input  rd_data
   );

   modport regs (
      input  wr,
      input  sel,
      input  wr_data,
      output rd_data
   );

endinterface

`default_nettype wire

// ==== rtl/mem_io_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_io_decode (
   input  logic                             clk_in,
   input  logic                             reset,

   // MEM stage request, held until mem_ack
   input  logic                             mem_req,
   input  logic [mem_io_pkg::ADDR_SZ-1:0]   mem_addr,
   input  logic                             mem_rd,
   input  logic                             mem_wr,
   input  logic [mem_io_pkg::RSZ-1:0]       mem_wr_data,
   input  mem_io_pkg::size_t                mem_size,
   input  logic                             mem_zero_ext,

   output logic                             mem_ack,       // One cycle
   output logic [mem_io_pkg::RSZ-1:0]       mem_ack_data,
   output logic                             mem_ack_fault,

   port_if.ctrl                             dc_bus,        // To the L1 D$ port
   port_if.ctrl                             io_bus,        // To the external I/O port
   mmr_if.ctrl                              mmr            // Timer registers
);
   import mem_io_pkg::*;

   typedef enum logic [1:0] {
      TGT_DC,                                                // L1 data cache
      TGT_IO,                                                // External I/O
      TGT_REG,                                               // Timer register
      TGT_FAULT                                              // Bad internal access
   } tgt_t;

   logic           busy;                                     // Request in flight
   logic           accept;
   tgt_t           cls;                                      // Class of the address on mem_addr
   tgt_t           tgt;                                      // Class of the request in flight
   mmr_sel_t       reg_sel;
   logic           reg_hit;                                  // mem_addr names a timer register
   logic [RSZ-1:0] int_data;                                 // Register read, returned next cycle

   assign accept = mem_req & ~busy;

   // ----------------------------------------------------------
   // Address classification
   // ----------------------------------------------------------
   always_comb begin
      reg_hit = 1'b1;
      case (mem_addr)
         MSIP_ADDR:             reg_sel = MMR_MSIP;
         MTIME_ADDR:            reg_sel = MMR_MTIME_LO;
         MTIME_ADDR + 32'd4:    reg_sel = MMR_MTIME_HI;
         MTIMECMP_ADDR:         reg_sel = MMR_MTIMECMP_LO;
         MTIMECMP_ADDR + 32'd4: reg_sel = MMR_MTIMECMP_HI;
         default: begin
            reg_sel = MMR_MSIP;
            reg_hit = 1'b0;                                  // Hole in the internal window
         end
      endcase

      if ((mem_addr >= INT_IO_LO) && (mem_addr <= INT_IO_HI))
         cls = (reg_hit && (mem_size == SZ_WORD)) ? TGT_REG : TGT_FAULT;
      else if ((mem_addr >= EXT_IO_LO) && (mem_addr <= EXT_IO_HI))
         cls = TGT_IO;
      else
         cls = TGT_DC;
   end

   // Register access happens in the accept cycle itself
   assign mmr.sel     = reg_sel;
   assign mmr.wr_data = mem_wr_data;
   assign mmr.wr      = accept & (cls == TGT_REG) & mem_wr; // Write lands at the accept edge

   // ----------------------------------------------------------
   // Busy state and port starts
   // ----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (reset) begin
         busy         <= 1'b0;
         tgt          <= TGT_DC;
         dc_bus.start <= 1'b0;
         io_bus.start <= 1'b0;
      end else begin
         dc_bus.start <= accept & (cls == TGT_DC);          // Pulse in cycle after accept
         io_bus.start <= accept & (cls == TGT_IO);
         if (accept) begin
            busy <= 1'b1;
            tgt  <= cls;
         end else if (mem_ack)
            busy <= 1'b0;                                    // Idle after the ack cycle
      end
   end

   // Payloads, captured at the accept edge
   always_ff @(posedge clk_in) begin
      if (accept) begin
         int_data   <= mmr.rd_data;                          // Value before any write
         dc_bus.req <= dc_req_t'{rw_addr: mem_addr, rd: mem_rd, wr: mem_wr,
                                 wr_data: mem_wr_data, size: mem_size,
                                 zero_ext: mem_zero_ext};
         io_bus.req <= io_req_t'{addr: mem_addr, rd: mem_rd, wr: mem_wr,
                                 wr_data: mem_wr_data};
      end
   end

   // ----------------------------------------------------------
   // Response select
   // ----------------------------------------------------------
   always_comb begin
      case (tgt)
         TGT_DC: begin
            mem_ack       = dc_bus.done;
            mem_ack_data  = dc_bus.rsp.data;
            mem_ack_fault = 1'b0;                            // D$ never faults here
         end
         TGT_IO: begin
            mem_ack       = io_bus.done;
            mem_ack_data  = io_bus.rsp.data;
            mem_ack_fault = io_bus.rsp.fault;
         end
         default: begin
            mem_ack       = busy;                            // Internal, busy lasts one cycle
            mem_ack_data  = int_data;
            mem_ack_fault = (tgt == TGT_FAULT);
         end
      endcase
   end

   // A port reply may only surface for a request that is in flight
   a_ack_busy: assert property (@(posedge clk_in) disable iff (reset) mem_ack |-> busy);

endmodule

`default_nettype wire

// ==== rtl/bus_port.sv ====
`default_nettype none
`timescale 1ns/1ps

// Outward req/ack bus, one access at a time
module bus_port #(
   parameter type req_t = logic,
   parameter type rsp_t = logic
) (
   input  logic clk_in,
   input  logic reset,

   port_if.port ctrl,                                        // From the decoder

   output logic out_req,                                     // Held until ack
   output req_t out_req_data,
   input  logic ack,                                         // One cycle from the target
   input  rsp_t ack_rsp                                      // Valid with ack
);

   // ----------------------------------------------------------
   // Handshake control
   // ----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (reset) begin
         out_req   <= 1'b0;
         ctrl.done <= 1'b0;
      end else begin
         ctrl.done <= out_req & ack;                         // Pulse the cycle after ack
         if (ctrl.start)
            out_req <= 1'b1;                                 // Up from the edge after start
         else if (ack)
            out_req <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge clk_in) begin
      if (ctrl.start)
         out_req_data <= ctrl.req;
      if (out_req & ack)
         ctrl.rsp <= ack_rsp;                                // Returned with done
   end

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   // Decoder must wait for done before starting again
   a_no_overlap: assert property (@(posedge clk_in) disable iff (reset)
      ctrl.start |-> !out_req && !ctrl.done);

   // Target sees a steady request through all wait cycles
   a_req_stable: assert property (@(posedge clk_in) disable iff (reset)
      out_req && !ack |=> out_req && $stable(out_req_data));

endmodule

`default_nettype wire

// ==== rtl/clint.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint (
   input  logic clk_in,
   input  logic reset,

   mmr_if.regs  mmr,                                         // Word access from the decoder

   output logic time_irq,                                    // mtime >= mtimecmp
   output logic sw_irq                                       // msip bit 0
);
   import mem_io_pkg::*;

   logic [2*RSZ-1:0] mtime;                                  // Free running, one per clock
   logic [2*RSZ-1:0] mtimecmp;
   logic             msip;                                   // Only bit 0 is implemented

   logic             mtime_lo_wr, mtime_hi_wr;
   logic             mtimecmp_lo_wr, mtimecmp_hi_wr;
   logic             msip_wr;

   // Write decode
   assign msip_wr        = mmr.wr & (mmr.sel == MMR_MSIP);
   assign mtime_lo_wr    = mmr.wr & (mmr.sel == MMR_MTIME_LO);
   assign mtime_hi_wr    = mmr.wr & (mmr.sel == MMR_MTIME_HI);
   assign mtimecmp_lo_wr = mmr.wr & (mmr.sel == MMR_MTIMECMP_LO);
   assign mtimecmp_hi_wr = mmr.wr & (mmr.sel == MMR_MTIMECMP_HI);

   // ----------------------------------------------------------
   // Timer counter
   // ----------------------------------------------------------
   always_ff @(posedge clk_in) begin
      if (reset)
         mtime <= '0;
      else if (mtime_lo_wr)
         mtime[RSZ-1:0] <= mmr.wr_data;                      // High half holds, no count
      else if (mtime_hi_wr)
         mtime[2*RSZ-1:RSZ] <= mmr.wr_data;
      else
         mtime <= mtime + 64'd1;
   end

   // Compare and software interrupt registers
   always_ff @(posedge clk_in) begin
      if (reset) begin
         mtimecmp <= '1;                                     // Far future, no timer irq
         msip     <= 1'b0;
      end else begin
         if (mtimecmp_lo_wr)
            mtimecmp[RSZ-1:0] <= mmr.wr_data;
         if (mtimecmp_hi_wr)
            mtimecmp[2*RSZ-1:RSZ] <= mmr.wr_data;
         if (msip_wr)
            msip <= mmr.wr_data[0];
      end
   end

   // ----------------------------------------------------------
   // Read mux and interrupts
   // ----------------------------------------------------------
   always_comb begin
      case (mmr.sel)
         MMR_MTIME_LO:    mmr.rd_data = mtime[RSZ-1:0];
         MMR_MTIME_HI:    mmr.rd_data = mtime[2*RSZ-1:RSZ];
         MMR_MTIMECMP_LO: mmr.rd_data = mtimecmp[RSZ-1:0];
         MMR_MTIMECMP_HI: mmr.rd_data = mtimecmp[2*RSZ-1:RSZ];
         default:         mmr.rd_data = {{(RSZ-1){1'b0}}, msip}; // Upper msip bits read zero
      endcase
   end

   assign time_irq = (mtime >= mtimecmp);                    // Full 64 bit compare
   assign sw_irq   = msip;

endmodule

`default_nettype wire

// ==== rtl/mem_io_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_io_top (
   input  logic                             clk_in,
   input  logic                             reset,

   // MEM stage side
   input  logic                             mem_req,
   input  logic [mem_io_pkg::ADDR_SZ-1:0]   mem_addr,
   input  logic                             mem_rd,
   input  logic                             mem_wr,
   input  logic [mem_io_pkg::RSZ-1:0]       mem_wr_data,
   input  mem_io_pkg::size_t                mem_size,
   input  logic                             mem_zero_ext,
   output logic                             mem_ack,
   output logic [mem_io_pkg::RSZ-1:0]       mem_ack_data,
   output logic                             mem_ack_fault,

   // L1 data cache
   output logic                             dc_req,        // Held until dc_ack
   output logic [mem_io_pkg::ADDR_SZ-1:0]   dc_rw_addr,
   output logic                             dc_rd,
   output logic                             dc_wr,
   output logic [mem_io_pkg::RSZ-1:0]       dc_wr_data,
   output mem_io_pkg::size_t                dc_size,
   output logic                             dc_zero_ext,
   input  logic                             dc_ack,
   input  logic [mem_io_pkg::RSZ-1:0]       dc_ack_data,

   // External I/O
   output logic                             io_req,        // Held until io_ack
   output logic [mem_io_pkg::ADDR_SZ-1:0]   io_addr,
   output logic                             io_rd,
   output logic                             io_wr,
   output logic [mem_io_pkg::RSZ-1:0]       io_wr_data,
   input  logic                             io_ack,
   input  logic                             io_ack_fault,
   input  logic [mem_io_pkg::RSZ-1:0]       io_ack_data,

   // Interrupts
   output logic                             time_irq,
   output logic                             sw_irq
);
   import mem_io_pkg::*;

   port_if #(.req_t(dc_req_t), .rsp_t(dc_rsp_t)) dc_bus ();
   port_if #(.req_t(io_req_t), .rsp_t(io_rsp_t)) io_bus ();
   mmr_if                                        mmr ();

   dc_req_t dc_req_s;
   dc_rsp_t dc_rsp_s;
   io_req_t io_req_s;
   io_rsp_t io_rsp_s;

   // ----------------------------------------------------------
   // Struct to pin mapping
   // ----------------------------------------------------------
   assign dc_rw_addr  = dc_req_s.rw_addr;
   assign dc_rd       = dc_req_s.rd;
   assign dc_wr       = dc_req_s.wr;
   assign dc_wr_data  = dc_req_s.wr_data;
   assign dc_size     = dc_req_s.size;
   assign dc_zero_ext = dc_req_s.zero_ext;
   assign dc_rsp_s    = '{data: dc_ack_data};

   assign io_addr     = io_req_s.addr;
   assign io_rd       = io_req_s.rd;
   assign io_wr       = io_req_s.wr;
   assign io_wr_data  = io_req_s.wr_data;
   assign io_rsp_s    = '{data: io_ack_data, fault: io_ack_fault};

   // ----------------------------------------------------------
   // Blocks
   // ----------------------------------------------------------
   mem_io_decode decoder (
      .clk_in, .reset,
      .mem_req, .mem_addr, .mem_rd, .mem_wr, .mem_wr_data, .mem_size, .mem_zero_ext,
      .mem_ack, .mem_ack_data, .mem_ack_fault,
      .dc_bus (dc_bus.ctrl),
      .io_bus (io_bus.ctrl),
      .mmr    (mmr.ctrl)
   );

   bus_port #(.req_t(dc_req_t), .rsp_t(dc_rsp_t)) dc_port (
      .clk_in, .reset,
      .ctrl         (dc_bus.port),
      .out_req      (dc_req),
      .out_req_data (dc_req_s),
      .ack          (dc_ack),
      .ack_rsp      (dc_rsp_s)
   );

   bus_port #(.req_t(io_req_t), .rsp_t(io_rsp_t)) io_port (
      .clk_in, .reset,
      .ctrl         (io_bus.port),
      .out_req      (io_req),
      .out_req_data (io_req_s),
      .ack          (io_ack),
      .ack_rsp      (io_rsp_s)
   );

   clint timer (
      .clk_in, .reset,
      .mmr      (mmr.regs),
      .time_irq,
      .sw_irq
   );

endmodule

`default_nettype wire

// ==== dv/mem_io_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_io_tb;
   import mem_io_pkg::*;

   localparam int CLK_NS      = 10;
   localparam int NUM_TXN     = 400;
   localparam int WORST_LAT   = 6;                           // Accept edge to mem_ack, 3 wait cycles
   localparam int WATCHDOG_NS = NUM_TXN * WORST_LAT * CLK_NS   // Latency of every access
                              + NUM_TXN * 4 * CLK_NS           // Accept, drop and idle cycles
                              + 1000;                          // Reset and slack

   // DUT inputs, responder side set at declaration
   logic               clk_in = 1'b0;
   logic               reset, mem_req, mem_rd, mem_wr, mem_zero_ext;
   logic [ADDR_SZ-1:0] mem_addr;
   logic [RSZ-1:0]     mem_wr_data;
   size_t              mem_size;
   logic               dc_ack = 1'b0;
   logic [RSZ-1:0]     dc_ack_data = '0;
   logic               io_ack = 1'b0;
   logic               io_ack_fault = 1'b0;
   logic [RSZ-1:0]     io_ack_data = '0;

   // DUT outputs
   logic               mem_ack, mem_ack_fault, dc_req, dc_rd, dc_wr, dc_zero_ext;
   logic               io_req, io_rd, io_wr, time_irq, sw_irq;
   logic [RSZ-1:0]     mem_ack_data, dc_wr_data, io_wr_data;
   logic [ADDR_SZ-1:0] dc_rw_addr, io_addr;
   size_t              dc_size;

   integer             seed = 32'h3a0b_c26b;
   int                 mismatch_cnt = 0;
   int                 other_cnt = 0;
   int                 dc_seen_cnt = 0;                      // Requests seen by each responder
   int                 io_seen_cnt = 0;
   int                 rise_cnt = 0;
   int                 fall_cnt = 0;
   dc_req_t            dc_seen;                              // Last request acked on each bus
   io_req_t            io_seen;
   logic               stuck = 1'b0;                         // Some access never got mem_ack

   // Reference model of the timer block
   logic [2*RSZ-1:0]   m_mtime, m_mtimecmp;
   logic               m_msip, prev_irq;
   logic               wr_pend = 1'b0;                       // Register write lands at next edge
   int                 wr_idx = 0;
   logic [RSZ-1:0]     wr_val = '0;

   mem_io_top mem_io_top_i (.*);

   always #(CLK_NS / 2) clk_in = ~clk_in;

   // ----------------------------------------------------------
   // Helpers and compare tasks
   // ----------------------------------------------------------
   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   // Index 0 msip, 1/2 mtime lo/hi, 3/4 mtimecmp lo/hi
   function automatic logic [ADDR_SZ-1:0] reg_addr(input int idx);
      case (idx)
         0:       return MSIP_ADDR;
         1:       return MTIME_ADDR;
         2:       return MTIME_ADDR + 32'd4;
         3:       return MTIMECMP_ADDR;
         default: return MTIMECMP_ADDR + 32'd4;
      endcase
   endfunction

   function automatic int reg_index(input logic [ADDR_SZ-1:0] addr);
      for (int k = 0; k < 5; k++)
         if (reg_addr(k) == addr)
            return k;
      return -1;                                             // Hole in the map
   endfunction

   function automatic logic [RSZ-1:0] model_read(input int idx);
      case (idx)
         0:       return {{(RSZ-1){1'b0}}, m_msip};
         1:       return m_mtime[RSZ-1:0];
         2:       return m_mtime[2*RSZ-1:RSZ];
         3:       return m_mtimecmp[RSZ-1:0];
         default: return m_mtimecmp[2*RSZ-1:RSZ];
      endcase
   endfunction

   task automatic check_dc_req(input dc_req_t got, input dc_req_t exp);
      if (got !== exp) begin
         $display("MISMATCH dc_req at %0t: got %h expected %h", $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_dc_rsp(input dc_rsp_t got, input dc_rsp_t exp);
      if (got !== exp) begin
         $display("MISMATCH mem_ack_data (dc) at %0t: got %h expected %h", $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_io_req(input io_req_t got, input io_req_t exp);
      if (got !== exp) begin
         $display("MISMATCH io_req at %0t: got %h expected %h", $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_io_rsp(input io_rsp_t got, input io_rsp_t exp);
      if (got !== exp) begin
         $display("MISMATCH mem_ack_data/fault (io) at %0t: got %h expected %h",
                  $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_word(input string name, input logic [RSZ-1:0] got,
                             input logic [RSZ-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s at %0t: got %h expected %h", name, $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s at %0t: got %h expected %h", name, $time, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic report_and_finish(input bit timed_out);
      $display("Done: %0d mismatches, %0d other errors, time_irq rose %0d fell %0d",
               mismatch_cnt, other_cnt, rise_cnt, fall_cnt);
      if (timed_out || mismatch_cnt != 0 || other_cnt != 0)
         $display("SIMULATION FAILED");
      else
         $display("SIMULATION PASSED");
      $finish;
   endtask

   // ----------------------------------------------------------
   // Timer model, interrupt monitor, bus responders
   // ----------------------------------------------------------
   always @(posedge clk_in) begin
      if (reset) begin
         m_mtime    <= '0;
         m_mtimecmp <= '1;
         m_msip     <= 1'b0;
      end else begin
         if (wr_pend && wr_idx == 1)
            m_mtime[RSZ-1:0] <= wr_val;                      // Written edge does not count
         else if (wr_pend && wr_idx == 2)
            m_mtime[2*RSZ-1:RSZ] <= wr_val;
         else
            m_mtime <= m_mtime + 64'd1;
         if (wr_pend && wr_idx == 3)
            m_mtimecmp[RSZ-1:0] <= wr_val;
         if (wr_pend && wr_idx == 4)
            m_mtimecmp[2*RSZ-1:RSZ] <= wr_val;
         if (wr_pend && wr_idx == 0)
            m_msip <= wr_val[0];
      end
   end

   always @(negedge clk_in) begin
      if (reset == 1'b0) begin
         check_bit("time_irq", time_irq, m_mtime >= m_mtimecmp);
         check_bit("sw_irq", sw_irq, m_msip);
         if (time_irq && !prev_irq)
            rise_cnt++;
         if (!time_irq && prev_irq)
            fall_cnt++;
      end
      prev_irq = time_irq;
   end

   always begin : dc_responder
      int wait_n;
      @(posedge clk_in);
      #1;
      if (dc_req === 1'b1) begin
         wait_n = rand_below(4);                             // 0 to 3 wait cycles
         repeat (wait_n) begin
            @(posedge clk_in);
            #1;
         end
         dc_seen = '{rw_addr: dc_rw_addr, rd: dc_rd, wr: dc_wr, wr_data: dc_wr_data,
                     size: dc_size, zero_ext: dc_zero_ext};
         dc_ack_data = rand32();
         dc_ack      = 1'b1;
         dc_seen_cnt++;
         @(posedge clk_in);
         #1;
         dc_ack = 1'b0;                                      // Data stays for the check
      end
   end

   always begin : io_responder
      int wait_n;
      @(posedge clk_in);
      #1;
      if (io_req === 1'b1) begin
         wait_n = rand_below(4);
         repeat (wait_n) begin
            @(posedge clk_in);
            #1;
         end
         io_seen      = '{addr: io_addr, rd: io_rd, wr: io_wr, wr_data: io_wr_data};
         io_ack_data  = rand32();
         io_ack_fault = (rand_below(4) == 0);                // Device fault now and then
         io_ack       = 1'b1;
         io_seen_cnt++;
         @(posedge clk_in);
         #1;
         io_ack = 1'b0;
      end
   end

   // ----------------------------------------------------------
   // One MEM-stage access, driven 1 ns after an edge
   // ----------------------------------------------------------
   task automatic run_access(input logic [ADDR_SZ-1:0] addr, input logic rd, input logic wr,
                             input logic [RSZ-1:0] data, input size_t size, input logic zext);
      int             cls;                                   // 0 D$, 1 I/O, 2 register, 3 fault
      int             idx;
      int             lat;
      int             dc_before;
      int             io_before;
      logic [RSZ-1:0] exp_rd;
      idx = reg_index(addr);
      if (addr >= INT_IO_LO && addr <= INT_IO_HI)
         cls = (idx >= 0 && size == SZ_WORD) ? 2 : 3;
      else if (addr >= EXT_IO_LO && addr <= EXT_IO_HI)
         cls = 1;
      else
         cls = 0;
      exp_rd       = (cls == 2) ? model_read(idx) : '0;      // Value during the accept cycle
      dc_before    = dc_seen_cnt;
      io_before    = io_seen_cnt;
      mem_req      = 1'b1;
      mem_addr     = addr;
      mem_rd       = rd;
      mem_wr       = wr;
      mem_wr_data  = data;
      mem_size     = size;
      mem_zero_ext = zext;
      wr_pend      = (cls == 2) && wr;
      wr_idx       = idx;
      wr_val       = data;
      @(posedge clk_in);                                     // Accept edge, decoder is idle
      #1;
      wr_pend = 1'b0;
      @(negedge clk_in);
      lat = 1;
      while (mem_ack !== 1'b1 && lat <= WORST_LAT + 4) begin
         @(negedge clk_in);
         lat++;
      end
      if (mem_ack !== 1'b1) begin
         $display("ERROR: no mem_ack for address %h after %0d cycles", addr, lat);
         other_cnt++;
         stuck = 1'b1;
         return;
      end
      case (cls)
         0: begin
            check_dc_req(dc_seen, '{rw_addr: addr, rd: rd, wr: wr, wr_data: data,
                                    size: size, zero_ext: zext});
            check_dc_rsp(dc_rsp_t'(mem_ack_data), dc_rsp_t'(dc_ack_data));
            check_bit("mem_ack_fault", mem_ack_fault, 1'b0);
            if (dc_seen_cnt != dc_before + 1 || io_seen_cnt != io_before) begin
               $display("ERROR: cache access at %h did not give exactly one dc_req", addr);
               other_cnt++;
            end
         end
         1: begin
            check_io_req(io_seen, '{addr: addr, rd: rd, wr: wr, wr_data: data});
            check_io_rsp(io_rsp_t'({mem_ack_data, mem_ack_fault}),
                         io_rsp_t'({io_ack_data, io_ack_fault}));
            if (io_seen_cnt != io_before + 1 || dc_seen_cnt != dc_before) begin
               $display("ERROR: I/O access at %h did not give exactly one io_req", addr);
               other_cnt++;
            end
         end
         default: begin
            if (lat != 1) begin
               $display("ERROR: internal access at %h acked %0d cycles after accept", addr, lat);
               other_cnt++;
            end
            check_bit("mem_ack_fault", mem_ack_fault, cls == 3);
            if (cls == 2 && rd)
               check_word("mem_ack_data", mem_ack_data, exp_rd);
            if (dc_seen_cnt != dc_before || io_seen_cnt != io_before) begin
               $display("ERROR: internal access at %h reached an outward bus", addr);
               other_cnt++;
            end
         end
      endcase
      @(posedge clk_in);                                     // Decoder idle again
      #1;
      mem_req = 1'b0;
   endtask

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------
   initial begin
      int             kind;
      int             idx;
      logic           rd;
      logic [ADDR_SZ-1:0] addr;
      logic [RSZ-1:0] data;
      size_t          sz;
      reset        = 1'b1;
      mem_req      = 1'b0;
      mem_addr     = '0;
      mem_rd       = 1'b0;
      mem_wr       = 1'b0;
      mem_wr_data  = '0;
      mem_size     = SZ_WORD;
      mem_zero_ext = 1'b0;
      repeat (4) @(posedge clk_in);
      #1;
      reset = 1'b0;
      @(negedge clk_in);
      check_bit("mem_ack", mem_ack, 1'b0);                   // Quiet after reset
      check_bit("dc_req", dc_req, 1'b0);
      check_bit("io_req", io_req, 1'b0);
      check_bit("time_irq", time_irq, 1'b0);
      check_bit("sw_irq", sw_irq, 1'b0);
      @(posedge clk_in);
      #1;
      for (int i = 0; i < NUM_TXN && !stuck; i++) begin
         kind = rand_below(6);
         rd   = (rand_below(2) == 1);
         data = rand32();
         case (rand_below(3))
            0:       sz = SZ_BYTE;
            1:       sz = SZ_HALF;
            default: sz = SZ_WORD;
         endcase
         case (kind)
            0, 1: begin
               addr = rand32();
               if ((addr >= INT_IO_LO && addr <= INT_IO_HI) ||
                   (addr >= EXT_IO_LO && addr <= EXT_IO_HI))
                  addr = addr ^ 32'h8000_0000;               // Move into cache space
               run_access(addr, rd, !rd, data, sz, rand_below(2) == 1);
            end
            2: run_access(EXT_IO_LO | (rand32() & 32'h0FFF_FFFC), rd, !rd, data, sz, 1'b0);
            3, 4: begin
               idx = rand_below(5);
               if (idx == 1 || idx == 3)
                  data = m_mtime[RSZ-1:0] + 32'(rand_below(64)); // Just ahead of mtime
               else if (idx == 2 || idx == 4)
                  data = m_mtime[2*RSZ-1:RSZ];
               run_access(reg_addr(idx), rd, !rd, data, SZ_WORD, 1'b0);
            end
            default: begin
               if (rand_below(2) == 1)
                  run_access(INT_IO_LO + 32'h1000 + (rand32() & 32'h0000_0FFC),
                             rd, !rd, data, SZ_WORD, 1'b0);  // Unmapped internal word
               else
                  run_access(reg_addr(rand_below(5)), rd, !rd, data,
                             (rand_below(2) == 1) ? SZ_BYTE : SZ_HALF, 1'b0);
            end
         endcase
         if (rand_below(2) == 1) begin                       // Idle gap
            @(posedge clk_in);
            #1;
         end
      end
      if (rise_cnt == 0 || fall_cnt == 0) begin
         $display("ERROR: time_irq did not both rise and fall during the run");
         other_cnt++;
      end
      report_and_finish(1'b0);
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired after %0d ns with the run unfinished", WATCHDOG_NS);
      report_and_finish(1'b1);
   end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/mem_io_pkg.sv
rtl/port_if.sv
rtl/mmr_if.sv
rtl/mem_io_decode.sv
rtl/bus_port.sv
rtl/clint.sv
rtl/mem_io_top.sv
dv/mem_io_tb.sv

// ==== Makefile ====
# Verilator flow for the MEM-side I/O block

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module mem_io_top -f sim.f

sim:
	verilator --binary --timing --assert --top-module mem_io_tb -f sim.f --Mdir $(OBJ_DIR) -o mem_io_sim
	-$(OBJ_DIR)/mem_io_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
